// ==== include/saturn_params.svh ====
`ifndef SATURN_PARAMS_SVH
`define SATURN_PARAMS_SVH

// Main CPU bus
`define SAT_ADDR_W 25
`define SAT_DATA_W 32

// CD buffer RAM, 16-bit words
`define SAT_CD_ADDR_W 18

// Master rising enables per SMPC enable
`define SAT_SMPC_DIV 7

// Read of this high RAM address raises the debug hook
`define SAT_HOOK_ADDR 25'h00012B0

// Idle counter
`define SAT_WAITCNT_W 8

`endif

// ==== verilog/saturnPkg.sv ====
`include "saturn_params.svh"

package saturnPkg;

	typedef logic [`SAT_ADDR_W-1:0] cpuAddrT;
	typedef logic [`SAT_DATA_W-1:0] cpuDataT;
	typedef logic [`SAT_DATA_W/8-1:0] dqmT;
	typedef logic [7:0] smpcDataT;
	typedef logic [15:0] cdWordT;
	typedef logic [`SAT_CD_ADDR_W-1:0] cdAddrT;
	typedef logic [`SAT_WAITCNT_W-1:0] waitCntT;

	typedef enum logic [1:0] {
		idle,
		running,
		halted
	} breakStateT;

	// Master SH-2 bus as seen by the glue
	typedef struct packed {
		cpuAddrT address;
		cpuDataT writeData;
		dqmT     dqmN;
		logic    rdN;
		logic    cs3N;
	} cpuBusT;

	// From the DCC address decoder
	typedef struct packed {
		logic dramCeN;
		logic romCeN;
		logic sramCeN;
		logic smpcCeN;
	} memSelT;

	typedef struct packed {
		cpuAddrT address;
		cpuDataT writeData;
		dqmT     dqmN;
		logic    rdN;
		logic    romCsN;
		logic    sramCsN;
		logic    ramLCsN;
		logic    ramHCsN;
	} memPortT;

	// SH-1 sub-CPU bus
	typedef struct packed {
		cdAddrT address;
		cdWordT writeData;
		logic   wrlN;
		logic   wrhN;
		logic   rdN;
		logic   cs1N;
		logic   dack0;
	} cdSubBusT;

	typedef struct packed {
		cdAddrT     address;
		cdWordT     writeData;
		logic [1:0] we;
		logic       rd;
		logic       cs;
	} cdRamPortT;

endpackage

// ==== verilog/clockControl.sv ====
`timescale 1ns/1ps
`include "saturn_params.svh"

module clockControl (
	input  logic CLK,
	input  logic RST_N,
	input  logic ce,
	input  logic dbgPause,
	input  logic dbgBreak,
	input  logic dbgRun,
	input  logic vdp1Start,
	input  logic vdp1CmdEnd,
	output logic ceR,
	output logic ceF,
	output logic smpcCe,
	output logic smpcResN,
	output logic paused
);
	import saturnPkg::*;

	localparam int cntW = $clog2(`SAT_SMPC_DIV);

	breakStateT state;
	logic pause;
	logic phase;
	logic [cntW-1:0] smpcCnt;

	// Break on VDP1 draw start or command end, resume on debugger run
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= idle;
		end else if (vdp1Start) begin
			state <= dbgBreak ? halted : running;
		end else if (vdp1CmdEnd && state != idle) begin
			state <= dbgBreak ? halted : running;
		end else if (dbgRun && state == halted) begin
			state <= running;
		end
	end

	assign pause = dbgPause | (state == halted);
	assign paused = pause;

	// Master clock phase, frozen while paused
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			phase <= 1'b0;
		end else if (ce && !pause) begin
			phase <= ~phase;
		end
	end

	assign ceR = phase & ~pause;
	assign ceF = ~phase & ~pause;

	// SMPC runs at a seventh of the master rate
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			smpcCnt <= '0;
			smpcCe <= 1'b0;
			smpcResN <= 1'b0;
		end else begin
			smpcCe <= 1'b0;
			if (ceR) begin
				if (smpcCnt == cntW'(`SAT_SMPC_DIV - 1)) begin
					smpcCnt <= '0;
					smpcCe <= 1'b1;
				end else begin
					smpcCnt <= smpcCnt + cntW'(1);
				end
			end
			// Master reset released after the first SMPC tick
			if (smpcCe) begin
				smpcResN <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/cpuBusRouter.sv ====
`timescale 1ns/1ps

module cpuBusRouter (
	input  saturnPkg::cpuBusT   bus,
	input  saturnPkg::memSelT   sel,
	input  saturnPkg::cpuDataT  scuData,
	input  saturnPkg::smpcDataT smpcData,
	input  saturnPkg::cpuDataT  memData,
	input  logic                scuWaitN,
	input  logic                memWaitN,
	output saturnPkg::cpuDataT  cpuReadData,
	output logic                cpuWaitN,
	output saturnPkg::memPortT  memPort
);
	import saturnPkg::*;

	logic extAccess;
	cpuDataT smpcWide;

	// High RAM on CS3, the rest through the decoder
	assign extAccess = !bus.cs3N || !sel.dramCeN || !sel.romCeN || !sel.sramCeN;

	// SMPC byte appears on every lane
	assign smpcWide = {4{smpcData}};

	always_comb begin
		if (extAccess) begin
			cpuReadData = memData;
		end else if (!sel.smpcCeN) begin
			cpuReadData = smpcWide;
		end else begin
			cpuReadData = scuData;
		end
	end

	// Memory wait only matters for external accesses
	assign cpuWaitN = scuWaitN & (memWaitN | ~extAccess);

	assign memPort.address = bus.address;
	assign memPort.writeData = bus.writeData;
	assign memPort.dqmN = bus.dqmN;
	assign memPort.rdN = bus.rdN;
	assign memPort.romCsN = sel.romCeN;
	assign memPort.sramCsN = sel.sramCeN;
	assign memPort.ramLCsN = sel.dramCeN;
	assign memPort.ramHCsN = bus.cs3N;

endmodule

// ==== verilog/cdBusBridge.sv ====
`timescale 1ns/1ps

module cdBusBridge (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 cdCe,
	input  saturnPkg::cdSubBusT  sub,
	input  saturnPkg::cdWordT    ygrData,
	input  saturnPkg::cdWordT    cdRamQ,
	input  logic                 cdRamRdy,
	output logic                 shCeR,
	output logic                 shCeF,
	output saturnPkg::cdWordT    cdReadData,
	output logic                 cdWaitN,
	output saturnPkg::cdRamPortT cdRam
);
	import saturnPkg::*;

	logic phase;
	cdWordT ramWriteData;

	// SH-1 clock phase
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			phase <= 1'b0;
		end else if (cdCe) begin
			phase <= ~phase;
		end
	end

	assign shCeR = phase & cdCe;
	assign shCeF = ~phase & cdCe;

	// CS1 is the buffer RAM, everything else is YGR019
	assign cdReadData = !sub.cs1N ? cdRamQ : ygrData;
	assign cdWaitN = cdRamRdy;

	// DMA channel 0 moves sector data from YGR019 into the buffer
	assign ramWriteData = !sub.dack0 ? ygrData : sub.writeData;

	assign cdRam.address = sub.address;
	assign cdRam.writeData = ramWriteData;
	assign cdRam.we = ~{sub.wrhN, sub.wrlN};
	assign cdRam.rd = ~sub.rdN;
	assign cdRam.cs = ~sub.cs1N;

endmodule

// ==== verilog/busMonitor.sv ====
`timescale 1ns/1ps
`include "saturn_params.svh"

module busMonitor (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               ceR,
	input  saturnPkg::cpuBusT  bus,
	output saturnPkg::waitCntT waitCnt,
	output logic               hook
);
	import saturnPkg::*;

	localparam cpuAddrT hookAddr = `SAT_HOOK_ADDR;

	logic busActive;
	logic hookHit;

	// Any read or byte write counts as activity
	assign busActive = !bus.rdN || !(&bus.dqmN);
	assign hookHit = !bus.rdN && !bus.cs3N && (bus.address == hookAddr);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			waitCnt <= '0;
			hook <= 1'b0;
		end else if (ceR) begin
			if (busActive) begin
				waitCnt <= '0;
			end else begin
				waitCnt <= waitCnt + 1'b1;
			end
			// Sticky until reset
			if (hookHit) begin
				hook <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/systemGlue.sv ====
`timescale 1ns/1ps

module systemGlue (
	input  logic                 CLK,
	input  logic                 RST_N,

	input  saturnPkg::cpuBusT    cpuBus,
	input  saturnPkg::memSelT    memSel,
	input  saturnPkg::cpuDataT   scuData,
	input  logic                 scuWaitN,
	input  saturnPkg::smpcDataT  smpcData,
	input  saturnPkg::cpuDataT   memData,
	input  logic                 memWaitN,

	input  saturnPkg::cdSubBusT  cdSub,
	input  saturnPkg::cdWordT    ygrData,
	input  saturnPkg::cdWordT    cdRamQ,
	input  logic                 cdRamRdy,

	input  logic                 ce,
	input  logic                 cdCe,
	input  logic                 dbgPause,
	input  logic                 dbgBreak,
	input  logic                 dbgRun,
	input  logic                 vdp1Start,
	input  logic                 vdp1CmdEnd,

	output logic                 ceR,
	output logic                 ceF,
	output logic                 smpcCe,
	output logic                 smpcResN,
	output logic                 paused,

	output saturnPkg::cpuDataT   cpuReadData,
	output logic                 cpuWaitN,
	output saturnPkg::memPortT   memPort,

	output logic                 shCeR,
	output logic                 shCeF,
	output saturnPkg::cdWordT    cdReadData,
	output logic                 cdWaitN,
	output saturnPkg::cdRamPortT cdRam,

	output saturnPkg::waitCntT   waitCnt,
	output logic                 hook
);

	clockControl clockControl_i (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.ce         (ce),
		.dbgPause   (dbgPause),
		.dbgBreak   (dbgBreak),
		.dbgRun     (dbgRun),
		.vdp1Start  (vdp1Start),
		.vdp1CmdEnd (vdp1CmdEnd),
		.ceR        (ceR),
		.ceF        (ceF),
		.smpcCe     (smpcCe),
		.smpcResN   (smpcResN),
		.paused     (paused)
	);

	cpuBusRouter cpuBusRouter_i (
		.bus         (cpuBus),
		.sel         (memSel),
		.scuData     (scuData),
		.smpcData    (smpcData),
		.memData     (memData),
		.scuWaitN    (scuWaitN),
		.memWaitN    (memWaitN),
		.cpuReadData (cpuReadData),
		.cpuWaitN    (cpuWaitN),
		.memPort     (memPort)
	);

	cdBusBridge cdBusBridge_i (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.cdCe       (cdCe),
		.sub        (cdSub),
		.ygrData    (ygrData),
		.cdRamQ     (cdRamQ),
		.cdRamRdy   (cdRamRdy),
		.shCeR      (shCeR),
		.shCeF      (shCeF),
		.cdReadData (cdReadData),
		.cdWaitN    (cdWaitN),
		.cdRam      (cdRam)
	);

	// Monitor runs on the master rising enable
	busMonitor busMonitor_i (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.ceR     (ceR),
		.bus     (cpuBus),
		.waitCnt (waitCnt),
		.hook    (hook)
	);

endmodule

// ==== tests/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
	output logic CLK,
	output logic RST_N
);

	// 4 ns period
	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Reset held over two rising edges, released on a falling edge
	initial begin
		RST_N = 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
	end

endmodule

// ==== tests/systemGlue_sva.sv ====
`timescale 1ns/1ps

module systemGlue_sva (
	input logic               CLK,
	input logic               RST_N,
	input logic               ceR,
	input logic               ceF,
	input logic               paused,
	input logic               smpcCe,
	input logic               smpcResN,
	input logic               hook,
	input saturnPkg::waitCntT waitCnt
);

	enablesExclusive: assert property (@(posedge CLK) disable iff (!RST_N)
		!(ceR && ceF))
		else $error("ceR and ceF high in the same cycle");

	// No master enable of either phase while the clock is paused
	enablesStopWhenPaused: assert property (@(posedge CLK) disable iff (!RST_N)
		paused |-> (!ceR && !ceF))
		else $error("master enable active while paused");

	smpcCeSingleCycle: assert property (@(posedge CLK) disable iff (!RST_N)
		smpcCe |=> !smpcCe)
		else $error("smpcCe high for two cycles");

	smpcResNSticky: assert property (@(posedge CLK) disable iff (!RST_N)
		smpcResN |=> smpcResN)
		else $error("smpcResN fell after release");

	// Sampled away from the rising edge so that the async reset has settled
	resetValues: assert property (@(negedge CLK)
		!RST_N |-> (!ceR && !smpcCe && !smpcResN && !hook && waitCnt == '0))
		else $error("outputs not at reset values during reset");

endmodule

bind systemGlue systemGlue_sva systemGlue_sva_i (.*);

// ==== tests/systemGlue_tb.sv ====
`timescale 1ns/1ps
`include "saturn_params.svh"

module systemGlue_tb;
	import saturnPkg::*;

	localparam int randomCycles = 400;
	localparam int idleCmdEndCycles = 4;
	localparam int resetTimeout = 10;
	localparam int hookTimeout = 64;

	logic CLK;
	logic RST_N;

	cpuBusT cpuBus;
	memSelT memSel;
	cpuDataT scuData;
	logic scuWaitN;
	smpcDataT smpcData;
	cpuDataT memData;
	logic memWaitN;
	cdSubBusT cdSub;
	cdWordT ygrData;
	cdWordT cdRamQ;
	logic cdRamRdy;
	logic ce;
	logic cdCe;
	logic dbgPause;
	logic dbgBreak;
	logic dbgRun;
	logic vdp1Start;
	logic vdp1CmdEnd;

	logic ceR;
	logic ceF;
	logic smpcCe;
	logic smpcResN;
	logic paused;
	cpuDataT cpuReadData;
	logic cpuWaitN;
	memPortT memPort;
	logic shCeR;
	logic shCeF;
	cdWordT cdReadData;
	logic cdWaitN;
	cdRamPortT cdRam;
	waitCntT waitCnt;
	logic hook;

	// Reference model state, updated on each rising edge
	breakStateT modelState;
	logic modelPhase;
	int modelSmpcCnt;
	logic modelSmpcCe;
	logic modelSmpcResN;
	logic modelCdPhase;
	waitCntT modelWaitCnt;
	logic modelHook;

	tbClock tbClock_i (.CLK(CLK), .RST_N(RST_N));

	systemGlue systemGlue_i (.*);

	task automatic checkValue(input string what, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
			$display("Test failed");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic initializeInputs();
		cpuBus = '0;
		cpuBus.dqmN = '1;
		cpuBus.rdN = 1'b1;
		cpuBus.cs3N = 1'b1;
		memSel = '1;
		scuData = '0;
		scuWaitN = 1'b1;
		smpcData = '0;
		memData = '0;
		memWaitN = 1'b1;
		cdSub = '0;
		cdSub.wrlN = 1'b1;
		cdSub.wrhN = 1'b1;
		cdSub.rdN = 1'b1;
		cdSub.cs1N = 1'b1;
		cdSub.dack0 = 1'b1;
		ygrData = '0;
		cdRamQ = '0;
		cdRamRdy = 1'b1;
		ce = 1'b0;
		cdCe = 1'b0;
		dbgPause = 1'b0;
		dbgBreak = 1'b0;
		dbgRun = 1'b0;
		vdp1Start = 1'b0;
		vdp1CmdEnd = 1'b0;
	endtask

	task automatic resetModel();
		modelState = idle;
		modelPhase = 1'b0;
		modelSmpcCnt = 0;
		modelSmpcCe = 1'b0;
		modelSmpcResN = 1'b0;
		modelCdPhase = 1'b0;
		modelWaitCnt = '0;
		modelHook = 1'b0;
	endtask

	task automatic driveRandom(input logic hookRead, input logic idleCmdEnd);
		cpuBus.address = cpuAddrT'($urandom);
		cpuBus.writeData = $urandom;
		cpuBus.dqmN = ($urandom % 4 == 0) ? dqmT'($urandom) : 4'hF;
		cpuBus.rdN = ($urandom % 4 != 0);
		cpuBus.cs3N = 1'($urandom);
		memSel = memSelT'($urandom);
		scuData = $urandom;
		scuWaitN = ($urandom % 4 != 0);
		smpcData = smpcDataT'($urandom);
		memData = $urandom;
		memWaitN = ($urandom % 4 != 0);
		cdSub = cdSubBusT'({$urandom, $urandom});
		ygrData = cdWordT'($urandom);
		cdRamQ = cdWordT'($urandom);
		cdRamRdy = 1'($urandom);
		ce = ($urandom % 4 != 0);
		cdCe = 1'($urandom);
		dbgPause = ($urandom % 8 == 0);
		dbgBreak = 1'($urandom);
		dbgRun = ($urandom % 4 == 0);
		vdp1Start = ($urandom % 16 == 0);
		vdp1CmdEnd = ($urandom % 16 == 0);
		// High RAM read at the hook address, with the clock let run
		if (hookRead) begin
			cpuBus.address = `SAT_HOOK_ADDR;
			cpuBus.rdN = 1'b0;
			cpuBus.cs3N = 1'b0;
			ce = 1'b1;
			dbgPause = 1'b0;
			dbgRun = 1'b1;
			vdp1Start = 1'b0;
			vdp1CmdEnd = 1'b0;
		end
		// Command end with break armed before any draw start
		if (idleCmdEnd) begin
			dbgPause = 1'b0;
			dbgBreak = 1'b1;
			vdp1Start = 1'b0;
			vdp1CmdEnd = 1'b1;
		end
	endtask

	task automatic compareOutputs();
		logic pause;
		logic ext;
		cpuDataT readExp;
		pause = dbgPause || (modelState == halted);
		ext = !cpuBus.cs3N || !memSel.dramCeN || !memSel.romCeN || !memSel.sramCeN;
		if (ext) begin
			readExp = memData;
		end else if (!memSel.smpcCeN) begin
			readExp = {smpcData, smpcData, smpcData, smpcData};
		end else begin
			readExp = scuData;
		end
		checkValue("paused", 64'(paused), 64'(pause));
		checkValue("ceR", 64'(ceR), 64'(modelPhase && !pause));
		checkValue("ceF", 64'(ceF), 64'(!modelPhase && !pause));
		checkValue("smpcCe", 64'(smpcCe), 64'(modelSmpcCe));
		checkValue("smpcResN", 64'(smpcResN), 64'(modelSmpcResN));
		checkValue("waitCnt", 64'(waitCnt), 64'(modelWaitCnt));
		checkValue("hook", 64'(hook), 64'(modelHook));
		checkValue("cpuReadData", 64'(cpuReadData), 64'(readExp));
		checkValue("cpuWaitN", 64'(cpuWaitN), 64'(scuWaitN && (memWaitN || !ext)));
		checkValue("memPort.address", 64'(memPort.address), 64'(cpuBus.address));
		checkValue("memPort.writeData", 64'(memPort.writeData), 64'(cpuBus.writeData));
		checkValue("memPort.dqmN", 64'(memPort.dqmN), 64'(cpuBus.dqmN));
		checkValue("memPort.rdN", 64'(memPort.rdN), 64'(cpuBus.rdN));
		checkValue("memPort.romCsN", 64'(memPort.romCsN), 64'(memSel.romCeN));
		checkValue("memPort.sramCsN", 64'(memPort.sramCsN), 64'(memSel.sramCeN));
		checkValue("memPort.ramLCsN", 64'(memPort.ramLCsN), 64'(memSel.dramCeN));
		checkValue("memPort.ramHCsN", 64'(memPort.ramHCsN), 64'(cpuBus.cs3N));
		checkValue("shCeR", 64'(shCeR), 64'(modelCdPhase && cdCe));
		checkValue("shCeF", 64'(shCeF), 64'(!modelCdPhase && cdCe));
		checkValue("cdReadData", 64'(cdReadData), 64'(!cdSub.cs1N ? cdRamQ : ygrData));
		checkValue("cdWaitN", 64'(cdWaitN), 64'(cdRamRdy));
		checkValue("cdRam.address", 64'(cdRam.address), 64'(cdSub.address));
		checkValue("cdRam.writeData", 64'(cdRam.writeData),
			64'(!cdSub.dack0 ? ygrData : cdSub.writeData));
		checkValue("cdRam.we", 64'(cdRam.we), 64'({!cdSub.wrhN, !cdSub.wrlN}));
		checkValue("cdRam.rd", 64'(cdRam.rd), 64'(!cdSub.rdN));
		checkValue("cdRam.cs", 64'(cdRam.cs), 64'(!cdSub.cs1N));
	endtask

	task automatic advanceModel();
		logic pause;
		logic rise;
		pause = dbgPause || (modelState == halted);
		rise = modelPhase && !pause;
		modelSmpcResN = modelSmpcResN || modelSmpcCe;
		modelSmpcCe = 1'b0;
		if (rise) begin
			if (modelSmpcCnt == `SAT_SMPC_DIV - 1) begin
				modelSmpcCnt = 0;
				modelSmpcCe = 1'b1;
			end else begin
				modelSmpcCnt++;
			end
			if (!cpuBus.rdN || cpuBus.dqmN != 4'hF) begin
				modelWaitCnt = '0;
			end else begin
				modelWaitCnt = modelWaitCnt + waitCntT'(1);
			end
			if (!cpuBus.rdN && !cpuBus.cs3N && cpuBus.address == `SAT_HOOK_ADDR) begin
				modelHook = 1'b1;
			end
		end
		if (ce && !pause) begin
			modelPhase = !modelPhase;
		end
		if (cdCe) begin
			modelCdPhase = !modelCdPhase;
		end
		if (vdp1Start) begin
			modelState = dbgBreak ? halted : running;
		end else if (vdp1CmdEnd && modelState != idle) begin
			modelState = dbgBreak ? halted : running;
		end else if (dbgRun && modelState == halted) begin
			modelState = running;
		end
	endtask

	task automatic runCycle(input logic hookRead, input logic idleCmdEnd);
		@(negedge CLK);
		driveRandom(hookRead, idleCmdEnd);
		#1;
		compareOutputs();
		@(posedge CLK);
		advanceModel();
	endtask

	task automatic waitForReset();
		int cycles = 0;
		@(posedge CLK);
		while (RST_N !== 1'b1) begin
			cycles++;
			if (cycles > resetTimeout) begin
				$display("Test failed");
				$fatal(1, "timeout: reset was never released");
			end
			@(posedge CLK);
		end
		// The DUT already ran on this edge
		advanceModel();
	endtask

	task automatic waitForHook();
		int cycles = 0;
		while (!modelHook) begin
			cycles++;
			if (cycles > hookTimeout) begin
				$display("Test failed");
				$fatal(1, "timeout: no master rising enable during the hook read");
			end
			runCycle(1'b1, 1'b0);
		end
	endtask

	initial begin
		void'($urandom(35));
		initializeInputs();
		resetModel();
		waitForReset();
		// Break FSM still idle, so these command ends must be ignored
		for (int i = 0; i < idleCmdEndCycles; i++) begin
			runCycle(1'b0, 1'b1);
		end
		for (int i = 0; i < randomCycles; i++) begin
			runCycle(1'b0, 1'b0);
		end
		waitForHook();
		for (int i = 0; i < randomCycles; i++) begin
			runCycle(1'b0, 1'b0);
		end
		checkValue("smpcResN at end", 64'(smpcResN), 64'(1'b1));
		checkValue("hook at end", 64'(hook), 64'(1'b1));
		$display("Test passed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+include
verilog/saturnPkg.sv
verilog/clockControl.sv
verilog/cpuBusRouter.sv
verilog/cdBusBridge.sv
verilog/busMonitor.sv
verilog/systemGlue.sv
tests/tbClock.sv
tests/systemGlue_sva.sv
tests/systemGlue_tb.sv

// ==== Makefile ====
# Build and run the systemGlue testbench with Verilator

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module systemGlue_tb -Mdir obj_dir -f compile.f
	./obj_dir/VsystemGlue_tb

clean:
	rm -rf obj_dir
